// File: src/rv32_pkg.sv
// shared widths, opcodes and encodings of the rv32 core, imported by every design file.
package rv32_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    localparam word_t RESET_PC = '0;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_WORD = 3'b010; // only word loads and stores.
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub and sra.

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        CLS_ALU, CLS_LUI, CLS_AUIPC, CLS_JUMP, CLS_JUMP_REG, CLS_BRANCH, CLS_LOAD, CLS_STORE
    } op_class_e;

    typedef enum logic [2:0] {
        ST_FETCH, ST_DECODE, ST_READ, ST_EXECUTE, ST_ACCESS, ST_WRITEBACK
    } stage_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [19:0] rest;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]  imm_hi;
        reg_idx_t    rs2;
        logic [7:0]  rs1_f3;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } s_fmt_t;

    typedef struct packed {
        logic        imm_12;
        logic [5:0]  imm_10_5;
        reg_idx_t    rs2;
        logic [7:0]  rs1_f3;
        logic [3:0]  imm_4_1;
        logic        imm_11;
        logic [6:0]  opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [11:0] rest;
    } u_fmt_t;

    typedef struct packed {
        logic        imm_20;
        logic [9:0]  imm_10_1;
        logic        imm_11;
        logic [7:0]  imm_19_12;
        logic [11:0] rest;
    } j_fmt_t;

    // one fetched word, viewed in the format its opcode selects.
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage

// File: src/rv32_dec_if.sv
// decoded instruction bus, driven by decode and read by execute and the sequencer.
`timescale 1ns/1ps

interface rv32_dec_if;
    import rv32_pkg::*;

    op_class_e  op_class;
    alu_op_e    alu_op;
    logic [2:0] funct3;
    reg_idx_t   rs1;
    reg_idx_t   rs2; // x0 unless the instruction reads rs2.
    reg_idx_t   rd;
    word_t      imm; // zero for register alu ops.

    modport dec (
        output op_class, alu_op, funct3, rs1, rs2, rd, imm
    );

    modport exe (
        input op_class, alu_op, funct3, imm
    );

    modport seq (
        input op_class
    );

endinterface

// File: src/rv32_regfile.sv
// general register file with two combinational read ports and one write port.
`timescale 1ns/1ps

module rv32_regfile (
    input  logic                i_clk,
    input  logic                i_rst,
    input  rv32_pkg::reg_idx_t  i_rs1,
    input  rv32_pkg::reg_idx_t  i_rs2,
    input  logic                i_wr_en,
    input  rv32_pkg::reg_idx_t  i_rd,
    input  rv32_pkg::word_t     i_wr_data,
    output rv32_pkg::word_t     o_rs1_data,
    output rv32_pkg::word_t     o_rs2_data
);
    import rv32_pkg::*;

    word_t regs [32];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && i_rd != '0) begin // x0 stays zero.
            regs[i_rd] <= i_wr_data;
        end
    end

    assign o_rs1_data = regs[i_rs1];
    assign o_rs2_data = regs[i_rs2];

    a_x0_zero: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_rs1 != '0 || o_rs1_data == '0) && (i_rs2 != '0 || o_rs2_data == '0));

endmodule

// File: src/rv32_decode.sv
// instruction decoder; turns the fetched word into class, alu op, register indices and immediate.
`timescale 1ns/1ps

module rv32_decode (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_dec_en,
    input  rv32_pkg::word_t i_instr,
    rv32_dec_if.dec         dec
);
    import rv32_pkg::*;

    instr_u    w;
    op_class_e cls_d;
    alu_op_e   alu_d;
    reg_idx_t  rs1_d;
    reg_idx_t  rs2_d;
    reg_idx_t  rd_d;
    word_t     imm_d;
    logic      alt;

    function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt_f7,
                                          input logic is_reg);
        case (f3)
            F3_ADD_SUB: return (alt_f7 && is_reg) ? ALU_SUB : ALU_ADD; // no subi.
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return alt_f7 ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    assign w   = i_instr;
    assign alt = (w.r.funct7 == F7_ALT);

    always_comb begin
        cls_d = CLS_ALU;
        alu_d = ALU_ADD;
        rs1_d = w.r.rs1;
        rs2_d = '0; // merged with the immediate in execute.
        rd_d  = w.r.rd;
        imm_d = {{20{w.i.imm[11]}}, w.i.imm};
        case (w.r.opcode)
            OPC_OP: begin
                alu_d = f3_to_alu(w.r.funct3, alt, 1'b1);
                rs2_d = w.r.rs2;
                imm_d = '0;
            end
            OPC_OP_IMM: alu_d = f3_to_alu(w.r.funct3, alt, 1'b0);
            OPC_LUI: begin
                cls_d = CLS_LUI;
                alu_d = ALU_PASS_B;
                imm_d = {w.u.imm, 12'b0};
            end
            OPC_AUIPC: begin
                cls_d = CLS_AUIPC;
                imm_d = {w.u.imm, 12'b0};
            end
            OPC_JAL: begin
                cls_d = CLS_JUMP;
                imm_d = {{11{w.j.imm_20}}, w.j.imm_20, w.j.imm_19_12, w.j.imm_11,
                         w.j.imm_10_1, 1'b0};
            end
            OPC_JALR: cls_d = CLS_JUMP_REG;
            OPC_BRANCH: begin
                cls_d = CLS_BRANCH;
                rs2_d = w.b.rs2;
                imm_d = {{19{w.b.imm_12}}, w.b.imm_12, w.b.imm_11, w.b.imm_10_5,
                         w.b.imm_4_1, 1'b0};
            end
            OPC_LOAD: begin
                if (w.r.funct3 == F3_WORD) begin
                    cls_d = CLS_LOAD;
                end else begin
                    rd_d = '0;
                end
            end
            OPC_STORE: begin
                if (w.r.funct3 == F3_WORD) begin
                    cls_d = CLS_STORE;
                    rs2_d = w.s.rs2;
                    imm_d = {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
                end else begin
                    rd_d = '0;
                end
            end
            default: rd_d = '0; // unknown opcode runs as addi into x0.
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            dec.op_class <= CLS_ALU;
            dec.alu_op   <= ALU_ADD;
            dec.rd       <= '0;
        end else if (i_dec_en) begin
            dec.op_class <= cls_d;
            dec.alu_op   <= alu_d;
            dec.rd       <= rd_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_dec_en) begin
            dec.funct3 <= w.r.funct3;
            dec.rs1    <= rs1_d;
            dec.rs2    <= rs2_d;
            dec.imm    <= imm_d;
        end
    end

endmodule

// File: src/rv32_execute.sv
// execute stage; latches operands, runs the alu and branch compare, and forms the next pc.
`timescale 1ns/1ps

module rv32_execute (
    input  logic            i_clk,
    input  logic            i_read_en,
    input  logic            i_exe_en,
    input  rv32_pkg::word_t i_pc,
    input  rv32_pkg::word_t i_rs1_data,
    input  rv32_pkg::word_t i_rs2_data,
    rv32_dec_if.exe         dec,
    output rv32_pkg::word_t o_alu_result,
    output rv32_pkg::word_t o_next_pc,
    output logic            o_taken,
    output rv32_pkg::word_t o_store_data
);
    import rv32_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t rs1_q;
    word_t rs2_q;
    word_t alu_d;
    logic  pc_based;
    logic  imm_only;
    logic  cond;

    assign pc_based = (dec.op_class == CLS_AUIPC) || (dec.op_class == CLS_JUMP)
                   || (dec.op_class == CLS_BRANCH);
    assign imm_only = (dec.op_class == CLS_BRANCH) || (dec.op_class == CLS_STORE);

    always_ff @(posedge i_clk) begin
        if (i_read_en) begin
            op_a  <= pc_based ? i_pc : i_rs1_data;
            // decode zeroes whichever of rs2 and imm is unused.
            op_b  <= imm_only ? dec.imm : (dec.imm | i_rs2_data);
            rs1_q <= i_rs1_data;
            rs2_q <= i_rs2_data;
        end
    end

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:    alu_d = op_a - op_b;
            ALU_SLL:    alu_d = op_a << op_b[4:0];
            ALU_SLT:    alu_d = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_d = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_d = op_a ^ op_b;
            ALU_SRL:    alu_d = op_a >> op_b[4:0];
            ALU_SRA:    alu_d = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_OR:     alu_d = op_a | op_b;
            ALU_AND:    alu_d = op_a & op_b;
            ALU_PASS_B: alu_d = op_b;
            default:    alu_d = op_a + op_b;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            F3_BEQ:  cond = (rs1_q == rs2_q);
            F3_BNE:  cond = (rs1_q != rs2_q);
            F3_BLT:  cond = ($signed(rs1_q) < $signed(rs2_q));
            F3_BGE:  cond = ($signed(rs1_q) >= $signed(rs2_q));
            F3_BLTU: cond = (rs1_q < rs2_q);
            F3_BGEU: cond = (rs1_q >= rs2_q);
            default: cond = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_exe_en) begin
            o_alu_result <= alu_d;
            o_next_pc    <= (dec.op_class == CLS_JUMP_REG) ? {alu_d[XLEN-1:1], 1'b0} : alu_d;
            o_taken      <= (dec.op_class == CLS_JUMP) || (dec.op_class == CLS_JUMP_REG)
                         || ((dec.op_class == CLS_BRANCH) && cond);
        end
    end

    assign o_store_data = rs2_q;

endmodule

// File: src/rv32_sequencer.sv
// stage sequencer of the core; steps one instruction through all stages and drives memory.
`timescale 1ns/1ps

module rv32_sequencer (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_mem_ready,
    input  rv32_pkg::word_t i_mem_rdata,
    input  rv32_pkg::word_t i_alu_result,
    input  rv32_pkg::word_t i_next_pc,
    input  logic            i_taken,
    input  rv32_pkg::word_t i_store_data,
    rv32_dec_if.seq         dec,
    output logic            o_mem_valid,
    output logic            o_mem_we,
    output rv32_pkg::word_t o_mem_addr,
    output rv32_pkg::word_t o_mem_wdata,
    output rv32_pkg::word_t o_instr,
    output rv32_pkg::word_t o_pc,
    output logic            o_dec_en,
    output logic            o_read_en,
    output logic            o_exe_en,
    output logic            o_wr_en,
    output rv32_pkg::word_t o_wr_data
);
    import rv32_pkg::*;

    stage_e stage;
    word_t  pc;
    word_t  pc_plus4;
    word_t  instr;
    word_t  load_data;
    logic   is_store;
    logic   is_mem;
    logic   writes_rd;

    assign pc_plus4  = pc + 32'd4;
    assign is_store  = (dec.op_class == CLS_STORE);
    assign is_mem    = is_store || (dec.op_class == CLS_LOAD);
    assign writes_rd = !is_store && (dec.op_class != CLS_BRANCH);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            stage       <= ST_FETCH;
            pc          <= RESET_PC;
            o_mem_valid <= 1'b0;
            o_mem_we    <= 1'b0;
        end else begin
            case (stage)
                ST_FETCH: begin
                    if (!o_mem_valid) begin
                        o_mem_valid <= 1'b1;
                        o_mem_we    <= 1'b0;
                    end else if (i_mem_ready) begin
                        o_mem_valid <= 1'b0;
                        stage       <= ST_DECODE;
                    end
                end
                ST_DECODE:  stage <= ST_READ;
                ST_READ:    stage <= ST_EXECUTE;
                ST_EXECUTE: stage <= is_mem ? ST_ACCESS : ST_WRITEBACK;
                ST_ACCESS: begin
                    if (!o_mem_valid) begin
                        o_mem_valid <= 1'b1;
                        o_mem_we    <= is_store;
                    end else if (i_mem_ready) begin
                        o_mem_valid <= 1'b0;
                        o_mem_we    <= 1'b0;
                        if (is_store) begin
                            pc    <= pc_plus4; // stores have no writeback.
                            stage <= ST_FETCH;
                        end else begin
                            stage <= ST_WRITEBACK;
                        end
                    end
                end
                ST_WRITEBACK: begin
                    pc    <= i_taken ? i_next_pc : pc_plus4;
                    stage <= ST_FETCH;
                end
                default: stage <= ST_FETCH;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (!o_mem_valid) begin
            o_mem_addr  <= (stage == ST_ACCESS) ? i_alu_result : pc;
            o_mem_wdata <= i_store_data;
        end
        if (o_mem_valid && i_mem_ready) begin
            if (stage == ST_FETCH) begin
                instr <= i_mem_rdata;
            end else begin
                load_data <= i_mem_rdata;
            end
        end
    end

    // lui comes back through the alu as the bare immediate.
    always_comb begin
        case (dec.op_class)
            CLS_JUMP, CLS_JUMP_REG: o_wr_data = pc_plus4; // return address.
            CLS_LOAD:               o_wr_data = load_data;
            default:                o_wr_data = i_alu_result;
        endcase
    end

    assign o_instr   = instr;
    assign o_pc      = pc;
    assign o_dec_en  = (stage == ST_DECODE);
    assign o_read_en = (stage == ST_READ);
    assign o_exe_en  = (stage == ST_EXECUTE);
    assign o_wr_en   = (stage == ST_WRITEBACK) && writes_rd;

    a_mem_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        o_mem_valid && !i_mem_ready |=> o_mem_valid && $stable(o_mem_addr)
            && $stable(o_mem_wdata) && $stable(o_mem_we));

endmodule

// File: src/rv32_core.sv
// top level of the multi-cycle rv32i core; joins the stages behind one memory port.
`timescale 1ns/1ps

module rv32_core (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_mem_ready,
    input  rv32_pkg::word_t i_mem_rdata,
    output logic            o_mem_valid,
    output rv32_pkg::word_t o_mem_addr,
    output rv32_pkg::word_t o_mem_wdata,
    output logic            o_mem_we
);
    import rv32_pkg::*;

    rv32_dec_if dec_bus ();

    word_t instr;
    word_t pc;
    word_t rs1_data;
    word_t rs2_data;
    word_t alu_result;
    word_t next_pc;
    word_t store_data;
    word_t wr_data;
    logic  taken;
    logic  dec_en;
    logic  read_en;
    logic  exe_en;
    logic  wr_en;

    rv32_sequencer u_sequencer (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_mem_ready  (i_mem_ready),
        .i_mem_rdata  (i_mem_rdata),
        .i_alu_result (alu_result),
        .i_next_pc    (next_pc),
        .i_taken      (taken),
        .i_store_data (store_data),
        .dec          (dec_bus.seq),
        .o_mem_valid  (o_mem_valid),
        .o_mem_we     (o_mem_we),
        .o_mem_addr   (o_mem_addr),
        .o_mem_wdata  (o_mem_wdata),
        .o_instr      (instr),
        .o_pc         (pc),
        .o_dec_en     (dec_en),
        .o_read_en    (read_en),
        .o_exe_en     (exe_en),
        .o_wr_en      (wr_en),
        .o_wr_data    (wr_data)
    );

    rv32_decode u_decode (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_dec_en (dec_en),
        .i_instr  (instr),
        .dec      (dec_bus.dec)
    );

    rv32_regfile u_regfile (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rs1      (dec_bus.rs1),
        .i_rs2      (dec_bus.rs2),
        .i_wr_en    (wr_en),
        .i_rd       (dec_bus.rd),
        .i_wr_data  (wr_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    rv32_execute u_execute (
        .i_clk        (i_clk),
        .i_read_en    (read_en),
        .i_exe_en     (exe_en),
        .i_pc         (pc),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .dec          (dec_bus.exe),
        .o_alu_result (alu_result),
        .o_next_pc    (next_pc),
        .o_taken      (taken),
        .o_store_data (store_data)
    );

endmodule

// File: testbench/tb_clock.sv
// clock and reset source of the testbench; a one-cycle request restarts the reset pulse.
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    input  logic i_rst_req,
    output logic o_clk,
    output logic o_rst
);
    logic clk_q = 1'b0;
    logic rst_q = 1'b1;
    int   count = RESET_CYCLES;

    always #(PERIOD_NS / 2) clk_q = ~clk_q;

    always @(posedge clk_q) begin
        if (i_rst_req) begin
            rst_q <= 1'b1;
            count <= RESET_CYCLES;
        end else if (count > 1) begin
            count <= count - 1;
        end else begin
            rst_q <= 1'b0; // released after the last reset edge.
            count <= 0;
        end
    end

    assign o_clk = clk_q;
    assign o_rst = rst_q;

endmodule

// File: testbench/tb_rv32_core.sv
// testbench of the rv32 core; runs a table of short programs on a memory with random ready delays.
`timescale 1ns/1ps

module tb_rv32_core;
    import rv32_pkg::*;

    localparam int          MAX_ROWS   = 48;
    localparam int          MAX_WORDS  = 16;
    localparam int          MEM_WORDS  = 256;
    localparam int          ROW_CYCLES = 200;
    localparam word_t       CHK_BASE   = 32'h0000_0200;
    localparam word_t       FILL       = 32'hbad0_bad0;
    localparam word_t       HALT       = 32'h0000_006f; // jal x0, 0.
    localparam word_t       NOP        = 32'h0000_0013;
    localparam logic [31:0] SEED       = 32'hdc5b_1d93;

    logic  clk;
    logic  rst;
    logic  rst_req = 1'b0;
    logic  mem_ready = 1'b0;
    word_t mem_rdata = '0;
    logic  mem_valid;
    logic  mem_we;
    word_t mem_addr;
    word_t mem_wdata;

    word_t mem [MEM_WORDS];
    int    delay = 0;
    int    stores = 0;
    word_t st_addr;
    word_t st_data;

    word_t prog_mem [MAX_ROWS][MAX_WORDS];
    int    prog_len [MAX_ROWS];
    word_t row_addr [MAX_ROWS];
    word_t row_exp [MAX_ROWS];
    string row_name [MAX_ROWS];
    word_t cur_prog [$];
    int    n_rows = 0;
    int    cur_row = 0;
    int    row_errs;
    int    pass_cnt;
    int    fail_cnt;
    word_t halt_addr;

    tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(4)) clk_gen (
        .i_rst_req (rst_req),
        .o_clk     (clk),
        .o_rst     (rst)
    );

    rv32_core dut (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_mem_ready (mem_ready),
        .i_mem_rdata (mem_rdata),
        .o_mem_valid (mem_valid),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .o_mem_we    (mem_we)
    );

    // memory model, reloaded with the current program while reset is held.
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= word_t'(i * 4) ^ FILL;
            end
            for (int i = 0; i < MAX_WORDS; i++) begin
                if (i < prog_len[cur_row]) begin
                    mem[i] <= prog_mem[cur_row][i];
                end
            end
            mem_ready <= 1'b0;
            stores    <= 0;
            delay     <= $urandom % 4;
        end else if (mem_ready) begin
            mem_ready <= 1'b0; // valid drops on this edge.
        end else if (mem_valid) begin
            if (delay > 0) begin
                delay <= delay - 1;
            end else begin
                mem_ready <= 1'b1;
                mem_rdata <= mem[mem_addr[9:2]];
                delay     <= $urandom % 4;
                if (mem_we) begin
                    mem[mem_addr[9:2]] <= mem_wdata;
                    st_addr <= mem_addr;
                    st_data <= mem_wdata;
                    stores  <= stores + 1;
                end
            end
        end
    end

    function automatic word_t encode_i(input logic [11:0] imm, input reg_idx_t rs1,
                                       input logic [2:0] f3, input reg_idx_t rd,
                                       input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t encode_s(input logic [11:0] imm, input reg_idx_t rs2,
                                       input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t encode_b(input logic [12:0] off, input reg_idx_t rs2,
                                       input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t encode_u(input logic [19:0] imm, input reg_idx_t rd,
                                       input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t encode_j(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // signed order is unsigned order with the sign bits flipped.
    function automatic logic signed_less(input word_t x, input word_t y);
        return (x ^ 32'h8000_0000) < (y ^ 32'h8000_0000);
    endfunction

    // each result bit takes the source bit sh places up, or the sign bit past the top.
    function automatic word_t shift_right_arith(input word_t v, input int sh);
        word_t r;
        for (int i = 0; i < XLEN; i++) begin
            r[i] = (i + sh < XLEN) ? v[i + sh] : v[XLEN-1];
        end
        return r;
    endfunction

    task automatic emit(input word_t w);
        cur_prog.push_back(w);
    endtask

    // lui plus addi; the upper part absorbs the sign of the low twelve bits.
    task automatic load_const(input reg_idx_t rd, input word_t v);
        word_t hi;
        hi = v + 32'h0000_0800;
        emit(encode_u(hi[31:12], rd, OPC_LUI));
        emit(encode_i(v[11:0], rd, F3_ADD_SUB, rd, OPC_OP_IMM));
    endtask

    // closes a program with a store of rs to the row's own address and a halt loop.
    task automatic add_row(input string name, input reg_idx_t rs, input word_t exp);
        word_t chk;
        chk = CHK_BASE + word_t'(n_rows * 4);
        emit(encode_s(chk[11:0], rs, 5'd0, F3_WORD));
        emit(HALT);
        for (int i = 0; i < cur_prog.size(); i++) begin
            prog_mem[n_rows][i] = cur_prog[i];
        end
        prog_len[n_rows] = cur_prog.size();
        row_addr[n_rows] = chk;
        row_exp[n_rows]  = exp;
        row_name[n_rows] = name;
        n_rows++;
        cur_prog.delete();
    endtask

    task automatic add_reg_op(input string name, input logic [6:0] f7, input logic [2:0] f3,
                              input word_t a, input word_t b, input word_t exp);
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit({f7, 5'd2, 5'd1, f3, 5'd3, OPC_OP});
        add_row(name, 5'd3, exp);
    endtask

    task automatic add_imm_op(input string name, input logic [2:0] f3, input logic [11:0] imm,
                              input word_t a, input word_t exp);
        load_const(5'd1, a);
        emit(encode_i(imm, 5'd1, f3, 5'd3, OPC_OP_IMM));
        add_row(name, 5'd3, exp);
    endtask

    // taken path leaves 0x22 in x3, fall-through leaves 0x11.
    task automatic add_branch(input string name, input logic [2:0] f3, input int p,
                              input word_t a, input word_t b);
        logic take;
        case (f3)
            F3_BEQ:  take = (a == b);
            F3_BNE:  take = (a != b);
            F3_BLT:  take = signed_less(a, b);
            F3_BGE:  take = !signed_less(a, b);
            F3_BLTU: take = (a < b);
            default: take = !(a < b);
        endcase
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(encode_b(13'd12, 5'd2, 5'd1, f3));
        emit(encode_i(12'h011, 5'd0, F3_ADD_SUB, 5'd3, OPC_OP_IMM));
        emit(encode_j(21'd8, 5'd0));
        emit(encode_i(12'h022, 5'd0, F3_ADD_SUB, 5'd3, OPC_OP_IMM));
        add_row($sformatf("%s pair %0d", name, p), 5'd3, take ? 32'h22 : 32'h11);
    endtask

    task automatic build_table();
        word_t a;
        word_t b;
        word_t s_imm;
        a = 32'hf0f0_1234;
        b = 32'h0000_0013;
        add_reg_op("ADD", 7'd0, F3_ADD_SUB, a, b, a + b);
        add_reg_op("SUB", F7_ALT, F3_ADD_SUB, a, b, a - b);
        add_reg_op("SLL", 7'd0, F3_SLL, a, b, a << b[4:0]);
        add_reg_op("SLT", 7'd0, F3_SLT, a, b, signed_less(a, b) ? 32'd1 : 32'd0);
        add_reg_op("SLTU", 7'd0, F3_SLTU, a, b, (a < b) ? 32'd1 : 32'd0);
        add_reg_op("XOR", 7'd0, F3_XOR, a, b, a ^ b);
        add_reg_op("SRL", 7'd0, F3_SRL_SRA, a, b, a >> b[4:0]);
        add_reg_op("SRA", F7_ALT, F3_SRL_SRA, a, b, shift_right_arith(a, b[4:0]));
        add_reg_op("OR", 7'd0, F3_OR, a, b, a | b);
        add_reg_op("AND", 7'd0, F3_AND, a, b, a & b);

        a = 32'h9abc_0f3c;
        s_imm = 32'hffff_ff85; // -123 sign-extended.
        add_imm_op("ADDI", F3_ADD_SUB, 12'hf85, a, a + s_imm);
        add_imm_op("SLTI", F3_SLT, 12'hf85, a, signed_less(a, s_imm) ? 32'd1 : 32'd0);
        add_imm_op("SLTIU", F3_SLTU, 12'hf85, a, (a < s_imm) ? 32'd1 : 32'd0);
        add_imm_op("XORI", F3_XOR, 12'hf85, a, a ^ s_imm);
        add_imm_op("ORI", F3_OR, 12'hf85, a, a | s_imm);
        add_imm_op("ANDI", F3_AND, 12'hf85, a, a & s_imm);
        add_imm_op("SLLI", F3_SLL, 12'h007, a, a << 7);
        add_imm_op("SRLI", F3_SRL_SRA, 12'h007, a, a >> 7);
        add_imm_op("SRAI", F3_SRL_SRA, 12'h407, a, shift_right_arith(a, 7));

        for (int p = 0; p < 3; p++) begin
            a = (p == 0) ? 32'hffff_fffd : 32'h0000_0005;
            b = (p == 1) ? 32'hffff_fffd : 32'h0000_0005;
            add_branch("BEQ", F3_BEQ, p, a, b);
            add_branch("BNE", F3_BNE, p, a, b);
            add_branch("BLT", F3_BLT, p, a, b);
            add_branch("BGE", F3_BGE, p, a, b);
            add_branch("BLTU", F3_BLTU, p, a, b);
            add_branch("BGEU", F3_BGEU, p, a, b);
        end

        emit(NOP);
        emit(encode_j(21'd8, 5'd5)); // at 0x4, lands on the store.
        emit(encode_i(12'h7ff, 5'd0, F3_ADD_SUB, 5'd5, OPC_OP_IMM));
        add_row("JAL", 5'd5, 32'h4 + 32'h4);

        emit(encode_i(12'h010, 5'd0, F3_ADD_SUB, 5'd6, OPC_OP_IMM));
        emit(encode_i(12'h001, 5'd6, 3'b000, 5'd5, OPC_JALR)); // 17 with bit 0 cleared.
        emit(encode_i(12'h7ff, 5'd0, F3_ADD_SUB, 5'd5, OPC_OP_IMM));
        emit(encode_i(12'h7ff, 5'd0, F3_ADD_SUB, 5'd5, OPC_OP_IMM));
        add_row("JALR", 5'd5, 32'h4 + 32'h4);

        emit(NOP);
        emit(NOP);
        emit(encode_u(20'h12345, 5'd7, OPC_AUIPC));
        add_row("AUIPC", 5'd7, 32'h8 + 32'h1234_5000);

        load_const(5'd1, 32'hcafe_f00d);
        load_const(5'd4, 32'h0000_0180);
        emit(encode_s(12'hff8, 5'd1, 5'd4, F3_WORD)); // word at 0x178.
        emit(encode_i(12'hff8, 5'd4, F3_WORD, 5'd2, OPC_LOAD));
        add_row("LW/SW", 5'd2, 32'hcafe_f00d);

        emit(encode_i(12'h055, 5'd0, F3_ADD_SUB, 5'd0, OPC_OP_IMM));
        add_row("x0", 5'd0, 32'h0);
    endtask

    task automatic run_reset();
        rst_req <= 1'b1;
        @(posedge clk);
        rst_req <= 1'b0;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
    endtask

    task automatic check_addr(input word_t got, input word_t exp, input string name);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s store address 0x%08h, expected 0x%08h",
                     $time, name, got, exp);
            row_errs++;
        end
    endtask

    task automatic check_data(input word_t got, input word_t exp, input string name);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s store data 0x%08h, expected 0x%08h",
                     $time, name, got, exp);
            row_errs++;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        pass_cnt = 0;
        fail_cnt = 0;
        build_table();
        for (int r = 0; r < n_rows; r++) begin
            cur_row <= r;
            run_reset();
            halt_addr = word_t'((prog_len[r] - 1) * 4);
            // done when the core fetches the halt loop.
            do begin
                @(posedge clk);
            end while (!(mem_valid && !mem_we && mem_addr == halt_addr));
            row_errs = 0;
            if (stores == 0) begin
                $display("%s: the program reached its end without storing anything", row_name[r]);
                row_errs++;
            end else begin
                check_addr(st_addr, row_addr[r], row_name[r]);
                check_data(st_data, row_exp[r], row_name[r]);
            end
            if (row_errs == 0) begin
                pass_cnt++;
            end else begin
                fail_cnt++;
            end
            $display("test %2d %s %s", r, row_name[r], (row_errs == 0) ? "ok" : "wrong");
        end
        $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #1;
        repeat (n_rows * ROW_CYCLES) @(posedge clk);
        $display("timeout: the programs did not finish within %0d cycles", n_rows * ROW_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: rv32_core.f
src/rv32_pkg.sv
src/rv32_dec_if.sv
src/rv32_regfile.sv
src/rv32_decode.sv
src/rv32_execute.sv
src/rv32_sequencer.sv
src/rv32_core.sv
testbench/tb_clock.sv
testbench/tb_rv32_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TB_TOP    ?= tb_rv32_core
RTL_TOP   ?= rv32_core
FILELIST  ?= rv32_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed
FAIL_MSG  := Some tests failed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && ! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
